//--- source/int_alu_pkg.sv
`default_nettype none

package int_alu_pkg;

    ////////////////////////////////////////////////////////////
    // Data word
    ////////////////////////////////////////////////////////////

    typedef logic signed [31:0] alu_word_t;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////

    // Upper two bits pick the group: 00 arithmetic, 01 logic, 1x special
    typedef enum logic [3:0] {
        op_add        = 4'b0000,
        op_sub        = 4'b0001,
        op_mul        = 4'b0010,
        op_div        = 4'b0011,
        op_not        = 4'b0100,
        op_and        = 4'b0101,
        op_or         = 4'b0110,
        op_xor        = 4'b0111,
        op_write_high = 4'b1000,
        op_write_low  = 4'b1001,
        op_itof       = 4'b1010,
        op_ftoi       = 4'b1011
    } alu_op_e;

    // Matches the low two bits of the arithmetic opcodes
    typedef enum logic [1:0] {
        icu_add = 2'b00,
        icu_sub = 2'b01,
        icu_mul = 2'b10,
        icu_div = 2'b11
    } icu_op_e;

    ////////////////////////////////////////////////////////////
    // Request and response
    ////////////////////////////////////////////////////////////

    // Only meaningful for arithmetic opcodes
    typedef struct packed {
        logic negative;
        logic zero;
    } alu_flag_t;

    typedef struct packed {
        alu_op_e   operation;
        alu_word_t op1;
        alu_word_t op2;
    } alu_req_t;

    typedef struct packed {
        alu_word_t out;
        alu_flag_t flag;
    } alu_rsp_t;

endpackage

`default_nettype wire

//--- source/int_compute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module int_compute_unit #(
    parameter int MUL_STEP_BITS = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  int_alu_pkg::icu_op_e   op,
    input  int_alu_pkg::alu_word_t op1,
    input  int_alu_pkg::alu_word_t op2,
    output int_alu_pkg::alu_word_t out,
    output int_alu_pkg::alu_flag_t flag,
    output logic                   done
);
    import int_alu_pkg::*;

    // Run cycles per operation
    localparam int MUL_CYCLES = 32 / MUL_STEP_BITS;
    localparam int DIV_CYCLES = 32;

    typedef enum logic [1:0] {
        idle,
        run,
        finish
    } icu_state_e;

    icu_state_e  state;
    logic [5:0]  count;
    icu_op_e     op_q;

    // Multiplicand or divisor magnitude
    logic [31:0] a_reg;
    // Multiplier, or dividend shifting out while quotient shifts in
    logic [31:0] b_reg;
    // Partial product or partial remainder
    logic [31:0] acc;
    logic        neg_q;
    logic        div_zero_q;
    alu_word_t   result;

    logic [31:0] prod_next;
    logic [32:0] rem_shift;
    logic [32:0] rem_diff;
    logic [31:0] quot_next;
    logic        last_step;

    ////////////////////////////////////////////////////////////
    // Step logic
    ////////////////////////////////////////////////////////////

    // Shift-add over MUL_STEP_BITS multiplier bits
    always_comb begin
        prod_next = acc;
        for (int i = 0; i < MUL_STEP_BITS; i++) begin
            if (b_reg[i]) begin
                prod_next = prod_next + (a_reg << i);
            end
        end
    end

    // Restoring divide, borrow bit says the trial subtract failed
    assign rem_shift = {acc, b_reg[31]};
    assign rem_diff  = rem_shift - {1'b0, a_reg};
    assign quot_next = {b_reg[30:0], ~rem_diff[32]};
    assign last_step = (count == 6'd1);

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            count <= '0;
        end else begin
            case (state)
                idle: begin
                    if (en) begin
                        if (op == icu_add || op == icu_sub) begin
                            state <= finish;
                        end else begin
                            state <= run;
                            count <= (op == icu_mul) ? 6'(MUL_CYCLES) : 6'(DIV_CYCLES);
                        end
                    end
                end
                run: begin
                    if (!en) begin
                        state <= idle;
                    end else if (last_step) begin
                        state <= finish;
                    end
                    count <= count - 6'd1;
                end
                finish: begin
                    if (!en) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == idle && en) begin
            op_q <= op;
            acc  <= '0;
            case (op)
                icu_add: result <= op1 + op2;
                icu_sub: result <= op1 - op2;
                icu_mul: begin
                    a_reg <= op1;
                    b_reg <= op2;
                end
                icu_div: begin
                    a_reg      <= op2[31] ? -op2 : op2;
                    b_reg      <= op1[31] ? -op1 : op1;
                    neg_q      <= op1[31] ^ op2[31];
                    div_zero_q <= (op2 == '0);
                end
            endcase
        end else if (state == run) begin
            if (op_q == icu_mul) begin
                acc   <= prod_next;
                a_reg <= a_reg << MUL_STEP_BITS;
                b_reg <= b_reg >> MUL_STEP_BITS;
                if (last_step) begin
                    result <= prod_next;
                end
            end else begin
                acc   <= rem_diff[32] ? rem_shift[31:0] : rem_diff[31:0];
                b_reg <= quot_next;
                // Truncated toward zero, all ones on divide by zero
                if (last_step) begin
                    result <= div_zero_q ? '1 : (neg_q ? -quot_next : quot_next);
                end
            end
        end
    end

    assign out           = result;
    assign flag.negative = result[31];
    assign flag.zero     = (result == '0);
    assign done          = (state == finish) && en;

endmodule

`default_nettype wire

//--- source/int_to_float.sv
`timescale 1ns/1ps
`default_nettype none

module int_to_float (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  int_alu_pkg::alu_word_t op1,
    output int_alu_pkg::alu_word_t out,
    output logic                   done
);
    typedef enum logic [1:0] {
        idle,
        norm,
        finish
    } itof_state_e;

    itof_state_e state;
    logic        sign_q;
    logic [31:0] mag;
    logic [7:0]  exp_q;
    logic [31:0] result;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    // Normalization ends on a zero magnitude or a leading one at bit 31
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (en) begin
                        state <= norm;
                    end
                end
                norm: begin
                    if (!en) begin
                        state <= idle;
                    end else if (mag == '0 || mag[31]) begin
                        state <= finish;
                    end
                end
                finish: begin
                    if (!en) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == idle && en) begin
            sign_q <= op1[31];
            mag    <= op1[31] ? -op1 : op1;
            // Bias 127 plus 31 for a leading one at bit 31
            exp_q  <= 8'd158;
        end else if (state == norm) begin
            if (mag == '0) begin
                result <= '0;
            end else if (mag[31]) begin
                // Hidden bit dropped, low bits truncated
                result <= {sign_q, exp_q, mag[30:8]};
            end else begin
                mag   <= mag << 1;
                exp_q <= exp_q - 8'd1;
            end
        end
    end

    assign out  = result;
    assign done = (state == finish) && en;

endmodule

`default_nettype wire

//--- source/float_to_int.sv
`timescale 1ns/1ps
`default_nettype none

module float_to_int (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  int_alu_pkg::alu_word_t op1,
    output int_alu_pkg::alu_word_t out,
    output logic                   done
);
    typedef enum logic [1:0] {
        idle,
        shift,
        finish
    } ftoi_state_e;

    ftoi_state_e state;
    logic        sign_q;
    logic        nan_q;
    logic [7:0]  exp_q;
    logic [31:0] mag;
    logic [7:0]  cnt;
    logic [31:0] result;

    logic        below_one;
    logic        overflow;

    // Magnitude under one, or at least 2^31 including inf and NaN
    assign below_one = (exp_q < 8'd127);
    assign overflow  = (exp_q >= 8'd158);

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (en) begin
                        state <= shift;
                    end
                end
                shift: begin
                    if (!en) begin
                        state <= idle;
                    end else if (below_one || overflow || cnt == '0) begin
                        state <= finish;
                    end
                end
                finish: begin
                    if (!en) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == idle && en) begin
            sign_q <= op1[31];
            exp_q  <= op1[30:23];
            nan_q  <= (op1[30:23] == 8'hff) && (op1[22:0] != '0);
            // Leading one sits at bit 31, worth 2^31 before shifting
            mag    <= {1'b1, op1[22:0], 8'h00};
            cnt    <= 8'd158 - op1[30:23];
        end else if (state == shift) begin
            if (below_one) begin
                result <= '0;
            end else if (overflow) begin
                result <= (sign_q && !nan_q) ? 32'h8000_0000 : 32'h7fff_ffff;
            end else if (cnt == '0) begin
                result <= sign_q ? -mag : mag;
            end else begin
                mag <= mag >> 1;
                cnt <= cnt - 8'd1;
            end
        end
    end

    assign out  = result;
    assign done = (state == finish) && en;

endmodule

`default_nettype wire

//--- source/integer_alu.sv
`timescale 1ns/1ps
`default_nettype none

module integer_alu #(
    parameter int MUL_STEP_BITS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  int_alu_pkg::alu_req_t req,
    output int_alu_pkg::alu_rsp_t rsp,
    output logic                  done,
    output logic                  en_knock_down
);
    import int_alu_pkg::*;

    alu_word_t icu_out;
    alu_word_t itof_out;
    alu_word_t ftoi_out;
    alu_flag_t icu_flag;
    icu_op_e   icu_op;

    logic      icu_en;
    logic      itof_en;
    logic      ftoi_en;
    logic      icu_done;
    logic      itof_done;
    logic      ftoi_done;

    assign icu_op = icu_op_e'(req.operation[1:0]);

    ////////////////////////////////////////////////////////////
    // Multi-cycle units
    ////////////////////////////////////////////////////////////

    int_compute_unit #(
        .MUL_STEP_BITS(MUL_STEP_BITS)
    ) i_icu (
        .clk  (clk),
        .rst_n(rst_n),
        .en   (icu_en),
        .op   (icu_op),
        .op1  (req.op1),
        .op2  (req.op2),
        .out  (icu_out),
        .flag (icu_flag),
        .done (icu_done)
    );

    int_to_float i_itof (
        .clk  (clk),
        .rst_n(rst_n),
        .en   (itof_en),
        .op1  (req.op1),
        .out  (itof_out),
        .done (itof_done)
    );

    float_to_int i_ftoi (
        .clk  (clk),
        .rst_n(rst_n),
        .en   (ftoi_en),
        .op1  (req.op1),
        .out  (ftoi_out),
        .done (ftoi_done)
    );

    ////////////////////////////////////////////////////////////
    // Decode and result select
    ////////////////////////////////////////////////////////////

    // Combinational opcodes report done and knock-down regardless of en
    always_comb begin
        icu_en        = 1'b0;
        itof_en       = 1'b0;
        ftoi_en       = 1'b0;
        done          = 1'b1;
        en_knock_down = 1'b1;
        rsp.out       = req.op1;
        rsp.flag      = '0;

        case (req.operation[3:2])
            2'b00: begin
                icu_en        = en;
                en_knock_down = en;
                done          = icu_done;
                rsp.out       = icu_out;
                rsp.flag      = icu_flag;
            end
            2'b01: begin
                case (req.operation)
                    op_not:  rsp.out = ~req.op1;
                    op_and:  rsp.out = req.op1 & req.op2;
                    op_or:   rsp.out = req.op1 | req.op2;
                    default: rsp.out = req.op1 ^ req.op2;
                endcase
            end
            default: begin
                case (req.operation)
                    op_write_high: rsp.out = {req.op2[15:0], req.op1[15:0]};
                    op_write_low:  rsp.out = {req.op1[31:16], req.op2[15:0]};
                    op_itof: begin
                        itof_en       = en;
                        en_knock_down = en;
                        done          = itof_done;
                        rsp.out       = itof_out;
                    end
                    // Float to int, also taken by the unused 11xx codes
                    default: begin
                        ftoi_en       = en;
                        en_knock_down = en;
                        done          = ftoi_done;
                        rsp.out       = ftoi_out;
                    end
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

//--- dv/alu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module alu_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  en,
    input int_alu_pkg::alu_req_t req,
    input int_alu_pkg::alu_rsp_t rsp,
    input logic                  done,
    input logic                  en_knock_down,
    input logic                  icu_en,
    input logic                  itof_en,
    input logic                  ftoi_en
);
    import int_alu_pkg::*;

    logic multi_cycle;

    assign multi_cycle = !((req.operation[3:2] == 2'b01) ||
                           (req.operation == op_write_high) ||
                           (req.operation == op_write_low));

    ////////////////////////////////////////////////////////////
    // Handshake protocol
    ////////////////////////////////////////////////////////////

    // Units come out of reset idle
    done_after_reset: assert property (
        @(posedge clk) !rst_n |=> (!multi_cycle || !done)
    ) else $error("done high in the cycle after reset");

    knock_down_follows_en: assert property (
        @(posedge clk) disable iff (!rst_n) multi_cycle |-> (en_knock_down == en)
    ) else $error("en_knock_down differs from en on a multi-cycle opcode");

    rsp_held: assert property (
        @(posedge clk) disable iff (!rst_n) (done && en) ##1 (done && en) |-> $stable(rsp)
    ) else $error("rsp changed while done and en were high");

    one_unit_enable: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({icu_en, itof_en, ftoi_en})
    ) else $error("more than one unit enable high");

endmodule

bind integer_alu alu_asserts i_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .req          (req),
    .rsp          (rsp),
    .done         (done),
    .en_knock_down(en_knock_down),
    .icu_en       (icu_en),
    .itof_en      (itof_en),
    .ftoi_en      (ftoi_en)
);

`default_nettype wire

//--- dv/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;
    import int_alu_pkg::*;

    localparam int    MUL_STEP_BITS = 2;
    localparam string VECTOR_FILE   = "dv/alu_input.txt";

    logic     clk;
    logic     rst_n;
    logic     en;
    alu_req_t req;
    alu_rsp_t rsp;
    logic     done;
    logic     en_knock_down;

    alu_req_t vec_req[$];
    alu_rsp_t vec_exp[$];
    int       cycle_count;
    int       cycle_limit;
    int       vectors_checked;
    int       seed;

    integer_alu #(
        .MUL_STEP_BITS(MUL_STEP_BITS)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .req          (req),
        .rsp          (rsp),
        .done         (done),
        .en_knock_down(en_knock_down)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input string name, input alu_word_t expected,
                              input alu_word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: out expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input alu_flag_t expected,
                              input alu_flag_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: flag expected %b, actual %b", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic expected,
                             input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: %s expected %b, actual %b", name, what, expected, actual);
            stop_on_error();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Vector file
    ////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] out;
        logic [1:0]  flag;
        alu_req_t    r;
        alu_rsp_t    e;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VECTOR_FILE);
            stop_on_error();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank and comment lines
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", op, a, b, out, flag);
                if (n == 5) begin
                    r.operation = alu_op_e'(op);
                    r.op1       = a;
                    r.op2       = b;
                    e.out       = out;
                    e.flag      = flag;
                    vec_req.push_back(r);
                    vec_exp.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    // Worst case per vector is a long convert plus gap and handshake
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: done never came within %0d cycles", cycle_limit);
            stop_on_error();
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        alu_req_t cur_req;
        alu_rsp_t cur_exp;
        alu_op_e  cur_op;
        string    name;
        logic     comb_op;
        int       gap;
        clk             = 1'b0;
        rst_n           = 1'b0;
        en              = 1'b0;
        req             = '0;
        cycle_count     = 0;
        cycle_limit     = 0;
        vectors_checked = 0;
        seed            = 32'hdf2d_0f7f;

        load_vectors();
        cycle_limit = vec_req.size() * 40 + 100;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < vec_req.size(); i++) begin
            cur_req = vec_req[i];
            cur_exp = vec_exp[i];
            cur_op  = cur_req.operation;
            name    = $sformatf("vec%0d_%s", i, cur_op.name());
            // Logic and half writes answer in the first cycle
            comb_op = (cur_op[3:2] == 2'b01) || (cur_op == op_write_high) ||
                      (cur_op == op_write_low);

            @(posedge clk);
            req <= cur_req;
            en  <= 1'b1;

            @(negedge clk);
            check_bit(name, "done in first cycle", comb_op, done);
            check_bit(name, "en_knock_down", 1'b1, en_knock_down);
            while (!done) begin
                @(negedge clk);
            end
            check_word(name, cur_exp.out, rsp.out);
            check_flag(name, cur_exp.flag, rsp.flag);
            vectors_checked++;

            // Request held through the cycle after done
            repeat (2) @(posedge clk);
            en <= 1'b0;
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);
        end

        @(posedge clk);
        if (vec_req.size() > 0 && vectors_checked == vec_req.size()) begin
            $display("Finished with no errors");
        end else begin
            $display("No vectors were run");
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/alu_input.txt
# Columns in hex: opcode op1 op2 expected_out expected_flag
# Flag is {negative, zero} and is 0 for non-arithmetic opcodes
4 0f0f00ff 00000000 f0f0ff00 0
5 12345678 0f0f0f0f 02040608 0
6 12345678 0f0f0f0f 1f3f5f7f 0
7 12345678 ffff0000 edcb5678 0
8 aaaa1234 5555beef beef1234 0
9 aaaa1234 5555beef aaaabeef 0
0 7fffffff 00000001 80000000 2
0 ffffffff 00000001 00000000 1
1 00000003 00000005 fffffffe 2
1 80000000 00000001 7fffffff 0
1 12345678 12345678 00000000 1
2 fffffffd 00000005 fffffff1 2
2 00010000 00010000 00000000 1
2 12345678 00000009 a3d70a38 2
2 fffffffe fffffffd 00000006 0
3 00000007 00000002 00000003 0
3 fffffff9 00000002 fffffffd 2
3 00000007 fffffffe fffffffd 2
3 fffffff9 fffffffe 00000003 0
3 00000064 00000000 ffffffff 2
3 80000000 00000001 80000000 2
3 00000001 00000005 00000000 1
a 00000001 00000000 3f800000 0
a fffffffa 00000000 c0c00000 0
a 00000000 00000000 00000000 0
a 7fffffff 00000000 4effffff 0
a 80000000 00000000 cf000000 0
b 40490fdb 00000000 00000003 0
b c0490fdb 00000000 fffffffd 0
b 3f000000 00000000 00000000 0
b 3f800000 00000000 00000001 0
b 4b91a2b3 00000000 01234566 0
b 4f000000 00000000 7fffffff 0
b ff800000 00000000 80000000 0
b ffc00000 00000000 7fffffff 0

//--- all.f
source/int_alu_pkg.sv
source/int_compute_unit.sv
source/int_to_float.sv
source/float_to_int.sv
source/integer_alu.sv
dv/alu_asserts.sv
dv/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ALU testbench, then search the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module alu_tb -f all.f -o alu_sim \
    && ./obj_dir/alu_sim > sim.log 2>&1 \
    || echo "Finished with errors" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && echo "Simulation FAILED" && exit 1
grep -q "Finished with no errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"
